/* rtl/audio_types_pkg.sv */
/*
 * audio types
 * vector widths with a meaning in the sound-effect path and the
 * clip player state encoding
 */
package audio_types_pkg;

	//----------------------------------------------------------
	// sample and clip position
	//----------------------------------------------------------
	// signed pcm sample sent to the codec
	typedef logic signed [15:0] sample_t;
	// index into the sample rom
	typedef logic [13:0] clip_addr_t;

	//----------------------------------------------------------
	// register interface
	//----------------------------------------------------------
	// playback rate divider
	typedef logic [15:0] rate_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [15:0] reg_data_t;

	// clip player fsm
	typedef enum logic
	{
		PLAYER_IDLE,
		PLAYER_RUN
	} player_state_t;

endpackage

/* rtl/audio_cfg_pkg.sv */
/*
 * audio configuration
 * clip length, register map, codec setup table, frame timing and
 * the triangle wave that fills the sample rom
 */
package audio_cfg_pkg;

	// clip length in samples
	localparam int CLIP_LEN = 11930;

	// register map
	localparam logic [1:0] REG_RATE  = 2'd0;
	localparam logic [1:0] REG_CTRL  = 2'd1;
	localparam logic [1:0] REG_START = 2'd2;

	//----------------------------------------------------------
	// codec setup words
	//----------------------------------------------------------
	localparam int CODEC_WORDS     = 4;
	localparam int CODEC_WORD_BITS = 16;
	localparam int CODEC_BIT_W     = $clog2(CODEC_WORD_BITS);
	localparam int CODEC_IDX_W     = $clog2(CODEC_WORDS);
	// reset, power up, 16 bit i2s format, activate
	localparam logic [CODEC_WORD_BITS-1:0] CODEC_TABLE [CODEC_WORDS] =
		'{16'h1e00, 16'h0c00, 16'h0e02, 16'h1201};

	//----------------------------------------------------------
	// serial frame
	//----------------------------------------------------------
	localparam int SLOT_BITS   = 16;
	// two Clk cycles per bit
	localparam int SLOT_CLKS   = 2 * SLOT_BITS;
	localparam int FRAME_CLKS  = 2 * SLOT_CLKS;
	localparam int FRAME_CNT_W = $clog2(FRAME_CLKS);

	// triangle wave, rising for TRI_HALF samples then falling
	localparam int TRI_STEP = 32;
	localparam int TRI_HALF = 1024;
	// offset that centres the wave on zero
	localparam int TRI_BASE = TRI_HALF * TRI_STEP / 2;

endpackage

/* rtl/clip_if.sv */
/*
 * clip bus
 * joins the clip player, the sample rom and the serializer
 */
`timescale 1ns/1ns

interface clip_if import audio_types_pkg::*;
();

	// play position from the player
	clip_addr_t addr;
	// high while the player is in run
	logic playing;
	// registered rom data for addr
	sample_t sample;
	// one cycle pulse at each frame start
	logic sample_req;

	//----------------------------------------------------------
	// modports
	//----------------------------------------------------------
	modport player
	(
		output addr,
		output playing,
		input sample_req
	);

	modport rom
	(
		input addr,
		output sample
	);

	modport serializer
	(
		input sample,
		input playing,
		output sample_req
	);

endinterface

/* rtl/codec_init.sv */
/*
 * codec setup sequencer
 * shifts the fixed setup words out on a two-wire port after reset,
 * MSB first, then holds init_done high
 */
`timescale 1ns/1ns

module codec_init import audio_cfg_pkg::*;
(
	input logic Clk,
	input logic rst_n,
	output logic cfg_sclk,
	output logic cfg_sdat,
	output logic init_done
);

	// position in the setup table
	logic [CODEC_BIT_W-1:0] bit_cnt;
	logic [CODEC_IDX_W-1:0] word_cnt;

	//----------------------------------------------------------
	// clock and counters
	//----------------------------------------------------------
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg_sclk <= 1'b0;
			bit_cnt <= '0;
			word_cnt <= '0;
			init_done <= 1'b0;
		end
		else if (!init_done)
		begin
			cfg_sclk <= ~cfg_sclk;
			// sclk going low, move on to the next bit
			if (cfg_sclk)
			begin
				if (bit_cnt == CODEC_BIT_W'(CODEC_WORD_BITS - 1))
				begin
					bit_cnt <= '0;
					if (word_cnt == CODEC_IDX_W'(CODEC_WORDS - 1))
					begin
						// last bit of last word sent
						init_done <= 1'b1;
					end
					else
					begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
				else
				begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// data follows the counters, so it only changes while sclk is low
	// line parks low once setup is over
	always_comb
	begin
		if (init_done)
			cfg_sdat = 1'b0;
		else
			cfg_sdat = CODEC_TABLE[word_cnt][CODEC_WORD_BITS - 1 - int'(bit_cnt)];
	end

endmodule

/* rtl/audio_ctrl_regs.sv */
/*
 * audio control registers
 * playback rate, halt level and the start strobe for the clip player
 */
`timescale 1ns/1ns

module audio_ctrl_regs
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input logic Clk,
	input logic rst_n,
	input logic reg_wr,
	input reg_addr_t reg_addr,
	input reg_data_t reg_wdata,
	output rate_t rate,
	output logic halt,
	output logic start
);

	//----------------------------------------------------------
	// write decode
	//----------------------------------------------------------
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rate <= '0;
			halt <= 1'b0;
		end
		else if (reg_wr)
		begin
			case (reg_addr)
				REG_RATE:
				begin
					// rate divider, used as is
					rate <= reg_wdata;
				end
				REG_CTRL:
				begin
					// bit 0 is the game-over halt
					halt <= reg_wdata[0];
				end
				default:
				begin
					// start and unused addresses hold no state
				end
			endcase
		end
	end

	//----------------------------------------------------------
	// start strobe
	//----------------------------------------------------------
	// write data is ignored, any write to REG_START fires once
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= reg_wr && (reg_addr == REG_START);
	end

endmodule

/* rtl/clip_player.sv */
/*
 * clip player
 * idle/run fsm that walks the clip address through the sample rom,
 * one step per rate period when the serializer asks for a sample
 */
`timescale 1ns/1ns

module clip_player
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input logic Clk,
	input logic rst_n,
	input logic init_done,
	input logic start,
	input logic halt,
	input rate_t rate,
	clip_if.player clip
);

	player_state_t state;
	player_state_t next_state;
	// rate counter, counts 0 through rate
	rate_t cnt;
	rate_t cnt_next;
	clip_addr_t addr_next;

	//----------------------------------------------------------
	// state, counter and address registers
	//----------------------------------------------------------
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= PLAYER_IDLE;
			cnt <= '0;
			clip.addr <= '0;
		end
		else
		begin
			state <= next_state;
			cnt <= cnt_next;
			clip.addr <= addr_next;
		end
	end

	//----------------------------------------------------------
	// next state
	//----------------------------------------------------------
	always_comb
	begin
		next_state = state;
		cnt_next = '0;
		addr_next = '0;
		case (state)
			PLAYER_IDLE:
			begin
				// start only counts once the codec is set up
				if (start && init_done && !halt)
					next_state = PLAYER_RUN;
			end
			PLAYER_RUN:
			begin
				if (halt || clip.addr == clip_addr_t'(CLIP_LEN - 1))
				begin
					// clip over or game over, back to address 0
					next_state = PLAYER_IDLE;
				end
				else
				begin
					// >= so a lowered rate still wraps
					if (cnt >= rate)
						cnt_next = '0;
					else
						cnt_next = cnt + 1'b1;
					// step only when the serializer takes a sample
					if (cnt == rate && clip.sample_req)
						addr_next = clip.addr + 1'b1;
					else
						addr_next = clip.addr;
				end
			end
			default:
			begin
				next_state = PLAYER_IDLE;
			end
		endcase
	end

	assign clip.playing = (state == PLAYER_RUN);

endmodule

/* rtl/clip_rom.sv */
/*
 * clip sample rom
 * CLIP_LEN samples of a triangle wave with a registered read
 */
`timescale 1ns/1ns

module clip_rom
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input logic Clk,
	clip_if.rom clip
);

	sample_t mem [CLIP_LEN];

	//----------------------------------------------------------
	// triangle fill
	//----------------------------------------------------------
	// rises for TRI_HALF samples then falls, centred on zero
	initial
	begin
		int phase;
		for (int i = 0; i < CLIP_LEN; i++)
		begin
			phase = i % (2 * TRI_HALF);
			if (phase < TRI_HALF)
				mem[i] = sample_t'(phase * TRI_STEP - TRI_BASE);
			else
				mem[i] = sample_t'((2 * TRI_HALF - phase) * TRI_STEP - TRI_BASE);
		end
	end

	// one cycle read latency
	always_ff @(posedge Clk)
	begin
		clip.sample <= mem[clip.addr];
	end

endmodule

/* rtl/sample_serializer.sv */
/*
 * sample serializer
 * bit clock at Clk/2, word clock framing a left and a right slot,
 * the same sample sent MSB first in both slots
 */
`timescale 1ns/1ns

module sample_serializer
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input logic Clk,
	input logic rst_n,
	clip_if.serializer clip,
	output logic bclk,
	output logic lrclk,
	output logic sdata
);

	// Clk cycles within the frame, wraps at FRAME_CLKS
	logic [FRAME_CNT_W-1:0] fcnt;
	// sample of this frame, reloaded for the right slot
	sample_t frame_smp;
	logic [SLOT_BITS-1:0] shreg;

	//----------------------------------------------------------
	// frame timing
	//----------------------------------------------------------
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fcnt <= '0;
			clip.sample_req <= 1'b0;
		end
		else
		begin
			fcnt <= fcnt + 1'b1;
			// high for the first cycle of each frame
			clip.sample_req <= (fcnt == FRAME_CNT_W'(FRAME_CLKS - 1));
		end
	end

	// even counts bclk low, upper half is the right slot
	assign bclk = fcnt[0];
	assign lrclk = fcnt[FRAME_CNT_W-1];

	//----------------------------------------------------------
	// shift register
	//----------------------------------------------------------
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			frame_smp <= '0;
			shreg <= '0;
		end
		else if (fcnt == FRAME_CNT_W'(FRAME_CLKS - 1))
		begin
			// frame start, silence unless the player runs
			frame_smp <= clip.playing ? clip.sample : '0;
			shreg <= clip.playing ? clip.sample : '0;
		end
		else if (fcnt == FRAME_CNT_W'(SLOT_CLKS - 1))
		begin
			// right slot repeats the left
			shreg <= frame_smp;
		end
		else if (fcnt[0])
		begin
			// bclk falling, next bit
			shreg <= shreg << 1;
		end
	end

	assign sdata = shreg[SLOT_BITS-1];

endmodule

/* rtl/audio_top.sv */
/*
 * audio playback top level
 * codec setup, control registers, clip player, sample rom and
 * serializer joined on the clip bus
 */
`timescale 1ns/1ns

module audio_top import audio_types_pkg::*;
(
	input logic Clk,
	input logic rst_n,
	input logic reg_wr,
	input reg_addr_t reg_addr,
	input reg_data_t reg_wdata,
	output logic cfg_sclk,
	output logic cfg_sdat,
	output logic cfg_done,
	output logic bclk,
	output logic lrclk,
	output logic sdata,
	output logic playing,
	output clip_addr_t clip_addr
);

	rate_t rate;
	logic halt;
	logic start;

	clip_if clip_bus();

	//----------------------------------------------------------
	// codec setup and control
	//----------------------------------------------------------
	codec_init codec_init_i
	(
		.Clk(Clk),
		.rst_n(rst_n),
		.cfg_sclk(cfg_sclk),
		.cfg_sdat(cfg_sdat),
		.init_done(cfg_done)
	);

	audio_ctrl_regs audio_ctrl_regs_i
	(
		.Clk(Clk),
		.rst_n(rst_n),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.rate(rate),
		.halt(halt),
		.start(start)
	);

	//----------------------------------------------------------
	// playback path
	//----------------------------------------------------------
	clip_player clip_player_i
	(
		.Clk(Clk),
		.rst_n(rst_n),
		.init_done(cfg_done),
		.start(start),
		.halt(halt),
		.rate(rate),
		.clip(clip_bus.player)
	);

	clip_rom clip_rom_i
	(
		.Clk(Clk),
		.clip(clip_bus.rom)
	);

	sample_serializer sample_serializer_i
	(
		.Clk(Clk),
		.rst_n(rst_n),
		.clip(clip_bus.serializer),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata)
	);

	// status outputs
	assign playing = clip_bus.playing;
	assign clip_addr = clip_bus.addr;

endmodule

/* bench/audio_sva.sv */
/*
 * audio playback checker
 * concurrent assertions on setup, clip stepping, clip end and halt,
 * bound into the top level
 */
`timescale 1ns/1ns

module audio_sva
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input logic Clk,
	input logic rst_n,
	input logic cfg_done,
	input logic playing,
	input clip_addr_t clip_addr,
	input rate_t rate,
	input logic halt
);

	// one flag per property, read by the testbench
	bit early_bad = 1'b0;
	bit done_bad = 1'b0;
	bit step_bad = 1'b0;
	bit gap_bad = 1'b0;
	bit end_bad = 1'b0;
	bit halt_bad = 1'b0;
	logic failed;
	clip_addr_t last_addr;
	// cycles since the last address change
	int gap;

	assign failed = early_bad | done_bad | step_bad | gap_bad | end_bad | halt_bad;

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_addr <= '0;
			gap <= 1000000;
		end
		else
		begin
			last_addr <= clip_addr;
			if (clip_addr != last_addr)
				gap <= 1;
			else if (gap < 1000000)
				gap <= gap + 1;
		end
	end

	//----------------------------------------------------------
	// setup
	//----------------------------------------------------------
	no_play_before_done: assert property (@(posedge Clk) disable iff (!rst_n)
		!cfg_done |-> !playing)
	else
	begin
		early_bad = 1'b1;
		$error("player ran before codec setup finished");
	end

	done_held: assert property (@(posedge Clk) disable iff (!rst_n)
		cfg_done |=> cfg_done)
	else
	begin
		done_bad = 1'b1;
		$error("cfg_done fell after setup");
	end

	//----------------------------------------------------------
	// clip stepping
	//----------------------------------------------------------
	// plus one or back to the clip start
	addr_step: assert property (@(posedge Clk) disable iff (!rst_n)
		$changed(clip_addr) |-> clip_addr == clip_addr_t'($past(clip_addr) + 1'b1)
			|| clip_addr == '0)
	else
	begin
		step_bad = 1'b1;
		$error("clip_addr jumped by more than one");
	end

	// rate sampled at the stepping edge
	step_gap: assert property (@(posedge Clk) disable iff (!rst_n)
		$changed(clip_addr) && clip_addr != '0 |-> gap >= int'($past(rate)) + 1)
	else
	begin
		gap_bad = 1'b1;
		$error("clip_addr stepped sooner than rate allows");
	end

	clip_end: assert property (@(posedge Clk) disable iff (!rst_n)
		playing && clip_addr == clip_addr_t'(CLIP_LEN - 1) |=> !playing && clip_addr == '0)
	else
	begin
		end_bad = 1'b1;
		$error("player did not stop at the clip end");
	end

	// also covers a start while halted
	halt_stops: assert property (@(posedge Clk) disable iff (!rst_n)
		halt |=> !playing && clip_addr == '0)
	else
	begin
		halt_bad = 1'b1;
		$error("player kept running while halt was set");
	end

endmodule

bind audio_top audio_sva audio_sva_i
(
	.Clk(Clk),
	.rst_n(rst_n),
	.cfg_done(cfg_done),
	.playing(playing),
	.clip_addr(clip_addr),
	.rate(rate),
	.halt(halt)
);

/* bench/audio_tb.sv */
/*
 * audio playback testbench
 * resets the subsystem, rebuilds the codec setup words and the
 * serial frames, plays a full clip and halts random playbacks
 */
`timescale 1ns/1ns

module audio_tb
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
();

	logic Clk = 1'b0;
	logic rst_n;
	logic reg_wr;
	reg_addr_t reg_addr;
	reg_data_t reg_wdata;
	logic cfg_sclk;
	logic cfg_sdat;
	logic cfg_done;
	logic bclk;
	logic lrclk;
	logic sdata;
	logic playing;
	clip_addr_t clip_addr;

	// setup word capture
	logic sclk_q = 1'b0;
	logic [15:0] cfg_word = '0;
	int cfg_bits = 0;
	// frame capture
	logic bclk_q = 1'b0;
	logic lr_q = 1'b0;
	logic [15:0] left_w = '0;
	logic [15:0] right_w = '0;
	int right_n = 0;
	int play_frames = 0;
	// player state one cycle back, and the state behind the current frame
	logic ctx_play = 1'b0;
	clip_addr_t ctx_addr = '0;
	logic frame_play = 1'b0;
	clip_addr_t frame_addr = '0;
	clip_addr_t run_peak = '0;
	clip_addr_t end_peak = '0;

	audio_top audio_top_i
	(
		.Clk(Clk),
		.rst_n(rst_n),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.cfg_sclk(cfg_sclk),
		.cfg_sdat(cfg_sdat),
		.cfg_done(cfg_done),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata),
		.playing(playing),
		.clip_addr(clip_addr)
	);

	initial
	begin
		forever #5 Clk = ~Clk;
	end

	//----------------------------------------------------------
	// reporting and reference rule
	//----------------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input int want, input int got);
		assert (want == got)
		else
			fail_run($sformatf("[ERROR] %0t ns %s expected %0d got %0d", $time, name, want, got));
	endtask

	// triangle from the trough, TRI_STEP per address
	function automatic sample_t tri_sample(input clip_addr_t addr);
		int phase;
		int level;
		phase = int'(addr) % (2 * TRI_HALF);
		level = (phase < TRI_HALF) ? phase : 2 * TRI_HALF - phase;
		return sample_t'(level * TRI_STEP - TRI_BASE);
	endfunction

	task automatic check_frame();
		sample_t want;
		check_value("sdata right slot", int'(sample_t'(left_w)), int'(sample_t'(right_w)));
		want = frame_play ? tri_sample(frame_addr) : sample_t'(0);
		check_value("sdata left slot", int'(want), int'(sample_t'(left_w)));
		if (frame_play)
			play_frames++;
	endtask

	//----------------------------------------------------------
	// output monitors, sampled on the falling edge
	//----------------------------------------------------------
	always @(negedge Clk)
	begin
		if (rst_n && cfg_sclk && !sclk_q)
		begin
			cfg_word = {cfg_word[14:0], cfg_sdat};
			cfg_bits++;
			if (cfg_bits > CODEC_WORDS * CODEC_WORD_BITS)
				fail_run("cfg_sclk kept toggling after the last setup word");
			else if (cfg_bits % CODEC_WORD_BITS == 0)
				check_value("cfg_sdat word", int'(CODEC_TABLE[cfg_bits / CODEC_WORD_BITS - 1]),
					int'(cfg_word));
		end
		sclk_q = cfg_sclk;
	end

	always @(negedge Clk)
	begin
		if (rst_n)
		begin
			// lrclk fell, frame built from the state one cycle back
			if (!lrclk && lr_q)
			begin
				frame_play = ctx_play;
				frame_addr = ctx_addr;
			end
			if (bclk && !bclk_q)
			begin
				if (lrclk)
				begin
					right_w = {right_w[14:0], sdata};
					right_n++;
				end
				else
					left_w = {left_w[14:0], sdata};
				if (right_n == SLOT_BITS)
				begin
					check_frame();
					right_n = 0;
				end
			end
			if (playing && clip_addr > run_peak)
				run_peak = clip_addr;
			if (ctx_play && !playing)
			begin
				end_peak = run_peak;
				run_peak = '0;
			end
		end
		bclk_q = bclk;
		lr_q = lrclk;
		ctx_play = playing;
		ctx_addr = clip_addr;
	end

	// bound checker flags
	always @(negedge Clk)
	begin
		if (audio_top_i.audio_sva_i.failed)
			fail_run("a bound assertion reported a failure");
	end

	//----------------------------------------------------------
	// stimulus helpers
	//----------------------------------------------------------
	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		@(negedge Clk);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(negedge Clk);
		reg_wr = 1'b0;
	endtask

	task automatic wait_setup(input int limit);
		int n;
		n = 0;
		while (!cfg_done && n < limit)
		begin
			@(negedge Clk);
			n++;
		end
		if (!cfg_done)
			fail_run("timeout waiting for cfg_done");
	endtask

	task automatic wait_playing(input logic level, input int limit);
		int n;
		n = 0;
		while (playing != level && n < limit)
		begin
			@(negedge Clk);
			n++;
		end
		if (playing != level)
			fail_run($sformatf("timeout waiting for playing to become %0d", level));
	endtask

	//----------------------------------------------------------
	// test sequence
	//----------------------------------------------------------
	initial
	begin
		rst_n = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		void'($urandom(32'hbaf7_d051));
		repeat (3) @(negedge Clk);
		rst_n = 1'b1;

		// reset values
		check_value("cfg_done", 0, int'(cfg_done));
		check_value("playing", 0, int'(playing));
		check_value("sdata", 0, int'(sdata));
		check_value("clip_addr", 0, int'(clip_addr));
		// start before setup is over is ignored
		write_reg(REG_START, 16'h0001);
		repeat (4) @(negedge Clk);
		check_value("playing", 0, int'(playing));

		wait_setup(4 * CODEC_WORDS * CODEC_WORD_BITS);
		@(negedge Clk);
		check_value("cfg setup bits", CODEC_WORDS * CODEC_WORD_BITS, cfg_bits);

		// whole clip at rate 0
		write_reg(REG_RATE, 16'h0000);
		write_reg(REG_START, 16'h0001);
		wait_playing(1'b1, 10);
		wait_playing(1'b0, CLIP_LEN * FRAME_CLKS + 1000);
		@(negedge Clk);
		check_value("clip_addr peak", CLIP_LEN - 1, int'(end_peak));
		check_value("clip_addr", 0, int'(clip_addr));
		assert (play_frames > 0)
		else
			fail_run("no frame was sent while playing");

		// random rates, halted at a random point
		// rates reach past one frame so the step spacing follows rate
		repeat (3)
		begin
			write_reg(REG_RATE, reg_data_t'($urandom_range(0, 255)));
			write_reg(REG_START, 16'h0001);
			wait_playing(1'b1, 10);
			repeat (4)
			begin
				repeat ($urandom_range(50, 400)) @(negedge Clk);
				write_reg(REG_RATE, reg_data_t'($urandom_range(0, 255)));
			end
			repeat ($urandom_range(1, 200)) @(negedge Clk);
			write_reg(REG_CTRL, 16'h0001);
			wait_playing(1'b0, 2);
			check_value("clip_addr", 0, int'(clip_addr));
			// start while halted
			write_reg(REG_START, 16'h0001);
			repeat (4) @(negedge Clk);
			check_value("playing", 0, int'(playing));
			write_reg(REG_CTRL, 16'h0000);
		end

		@(negedge Clk);
		if (audio_top_i.audio_sva_i.failed)
			fail_run("a bound assertion reported a failure");
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* compile.f */
rtl/audio_types_pkg.sv
rtl/audio_cfg_pkg.sv
rtl/clip_if.sv
rtl/codec_init.sv
rtl/audio_ctrl_regs.sv
rtl/clip_player.sv
rtl/clip_rom.sv
rtl/sample_serializer.sv
rtl/audio_top.sv
bench/audio_sva.sv
bench/audio_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert --timing -j 0
TOP      := audio_tb
FLIST    := compile.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
RUN_OPTS := +verilator+error+limit+100
PASS_MSG := STATUS: PASS
FAIL_MSG := STATUS: FAIL
SRCS     := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_OPTS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
